/* hdl/cdi_host_cfg.svh */
`ifndef CDI_HOST_CFG_SVH
`define CDI_HOST_CFG_SVH

// ==============================
// SDRAM preparation
// ==============================

// Number of 16-bit words cleared before the core leaves reset
`define CFG_RAM_ZERO_WORDS 524288

// Top five SDRAM address bits of the ROM area
`define CFG_ROM_REGION 5'b00100

// ==============================
// Download index codes, bits 7:6
// ==============================
`define CFG_IDX_MAIN_ROM   2'd0
`define CFG_IDX_SLAVE_WORM 2'd1
`define CFG_IDX_VMPEG_ROM  2'd2

`endif

/* hdl/cdi_host_pkg.sv */
package cdi_host_pkg;

    // Host download and sector buffer side
    typedef logic [24:0] ioctl_addr_t;
    typedef logic [15:0] ioctl_index_t;
    typedef logic [15:0] host_word_t;
    typedef logic [63:0] img_size_t;

    // Memory side
    typedef logic [24:0] sdram_addr_t;
    typedef logic [12:0] worm_adr_t;
    typedef logic [12:0] nvram_adr_t;
    typedef logic [7:0]  nvram_byte_t;

    // Listed from highest to lowest priority
    typedef enum logic [1:0] {
        ROM_DOWNLOAD,
        RAM_ZERO,
        REFRESH,
        IDLE
    } sdram_owner_t;

    typedef enum logic [3:0] {
        NVRAM_IDLE,
        NVRAM_WAIT_FOR_ACK,
        NVRAM_BACKUP0,
        NVRAM_BACKUP1,
        NVRAM_BACKUP2,
        NVRAM_BACKUP3,
        NVRAM_RESTORE0,
        NVRAM_RESTORE1,
        NVRAM_RESTORE2
    } nvram_state_t;

endpackage

/* hdl/media_status.sv */
module media_status (
    input  logic                    clk_sys,
    input  logic                    cditop_reset,
    input  logic                    user_reset,
    input  logic                    ioctl_download,
    input  logic                    ram_zero_done,
    input  logic                    reset_on_nvram_mount,
    input  logic                    nvram_media_change,
    input  cdi_host_pkg::img_size_t img_size,
    input  logic                    nvram_cpu_changed,
    input  logic                    osd_status,
    input  logic                    backup_started,
    output logic                    core_reset,
    output logic                    nvram_img_mount,
    output logic                    osd_opened,
    output logic                    backup_pending
);
    import cdi_host_pkg::*;

    logic nvram_mounted;
    logic osd_status_q;

    // A media change with an empty image is an eject
    assign nvram_img_mount = nvram_media_change && (img_size != img_size_t'(0));
    assign osd_opened      = osd_status && !osd_status_q;

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            core_reset     <= 1'b1;
            nvram_mounted  <= 1'b0;
            osd_status_q   <= 1'b0;
            backup_pending <= 1'b0;
        end else begin
            core_reset <= user_reset || ioctl_download || !ram_zero_done ||
                          (nvram_img_mount && reset_on_nvram_mount);
            osd_status_q <= osd_status;

            if (nvram_media_change) begin
                nvram_mounted <= (img_size != img_size_t'(0));
            end

            // Starting a backup wins over a core write in the same cycle
            if (core_reset || backup_started) begin
                backup_pending <= 1'b0;
            end else if (nvram_cpu_changed && nvram_mounted) begin
                backup_pending <= 1'b1;
            end
        end
    end

endmodule

/* hdl/sdram_prep_arbiter.sv */
`include "cdi_host_cfg.svh"

module sdram_prep_arbiter #(
    parameter int RAM_ZERO_WORDS = `CFG_RAM_ZERO_WORDS
) (
    input  logic                       clk_sys,
    input  logic                       cditop_reset,
    input  logic                       core_reset,
    input  logic                       sdram_busy,
    input  logic                       ioctl_download,
    input  logic                       ioctl_wr,
    input  cdi_host_pkg::ioctl_addr_t  ioctl_addr,
    input  cdi_host_pkg::ioctl_index_t ioctl_index,
    input  cdi_host_pkg::host_word_t   ioctl_dout,
    output cdi_host_pkg::sdram_addr_t  sdram_addr,
    output cdi_host_pkg::host_word_t   sdram_din,
    output logic                       sdram_wr,
    output logic                       sdram_rd,
    output logic                       sdram_refresh,
    output logic                       ram_zero_done,
    output logic                       download_overflow
);
    import cdi_host_pkg::*;

    // One extra bit so the count can reach RAM_ZERO_WORDS
    localparam int ZW = $clog2(RAM_ZERO_WORDS + 1);

    sdram_owner_t  owner;
    sdram_owner_t  owner_q;
    sdram_owner_t  owner_next;
    logic [ZW-1:0] zero_cnt;
    logic          busy_q;
    logic          download_q;
    logic          rom_full;
    logic          rom_wr;
    logic          cmd_done;
    logic          issue;
    sdram_addr_t   rom_addr;
    host_word_t    rom_data;

    assign rom_wr = ioctl_wr && (ioctl_index[7:6] == `CFG_IDX_MAIN_ROM ||
                                 ioctl_index[7:6] == `CFG_IDX_VMPEG_ROM);
    assign ram_zero_done = (zero_cnt == ZW'(RAM_ZERO_WORDS));

    // Command ends on busy falling, next one waits a cycle for the counters
    assign cmd_done = busy_q && !sdram_busy;
    assign issue    = !sdram_busy && !busy_q;

    // ==============================
    // Owner selection
    // ==============================
    always_comb begin
        owner_next = IDLE;
        if (core_reset) begin
            if (rom_full) begin
                owner_next = ROM_DOWNLOAD;
            end else if (!ram_zero_done) begin
                owner_next = RAM_ZERO;
            end else begin
                owner_next = REFRESH;
            end
        end
        // Keep the owner of the command in flight
        owner = sdram_busy ? owner_q : owner_next;
    end

    assign sdram_wr      = issue && (owner == ROM_DOWNLOAD || owner == RAM_ZERO);
    assign sdram_rd      = issue && (owner == REFRESH);
    assign sdram_refresh = issue && (owner == REFRESH);

    always_comb begin
        sdram_addr = sdram_addr_t'({zero_cnt, 1'b0});
        sdram_din  = '0;
        if (owner == ROM_DOWNLOAD) begin
            sdram_addr = rom_addr;
            sdram_din  = rom_data;
        end
    end

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            owner_q           <= IDLE;
            busy_q            <= 1'b0;
            download_q        <= 1'b0;
            rom_full          <= 1'b0;
            download_overflow <= 1'b0;
            zero_cnt          <= '0;
        end else begin
            owner_q    <= owner;
            busy_q     <= sdram_busy;
            download_q <= ioctl_download;

            if (rom_full && ioctl_wr) begin
                download_overflow <= 1'b1;
            end

            if (cmd_done && owner_q == ROM_DOWNLOAD) begin
                rom_full <= 1'b0;
            end
            if (rom_wr) begin
                rom_full <= 1'b1;
            end

            // New download clears the RAM again from the start
            if (ioctl_download && !download_q) begin
                zero_cnt <= '0;
            end else if (cmd_done && owner_q == RAM_ZERO) begin
                zero_cnt <= zero_cnt + 1'b1;
            end
        end
    end

    // Host data is little endian, the 68k side wants big endian
    always_ff @(posedge clk_sys) begin
        if (rom_wr) begin
            rom_addr <= {`CFG_ROM_REGION, ioctl_index[7], ioctl_addr[18:1], 1'b0};
            rom_data <= {ioctl_dout[7:0], ioctl_dout[15:8]};
        end
    end

endmodule

/* hdl/worm_byte_splitter.sv */
`include "cdi_host_cfg.svh"

module worm_byte_splitter (
    input  logic                       clk_sys,
    input  logic                       cditop_reset,
    input  logic                       ioctl_wr,
    input  cdi_host_pkg::ioctl_index_t ioctl_index,
    input  cdi_host_pkg::ioctl_addr_t  ioctl_addr,
    input  cdi_host_pkg::host_word_t   ioctl_dout,
    output cdi_host_pkg::worm_adr_t    worm_adr,
    output logic [7:0]                 worm_data,
    output logic                       worm_wr
);
    import cdi_host_pkg::*;

    logic       worm_hit;
    logic       worm_hit_q;
    logic [7:0] second_byte;

    assign worm_hit = ioctl_wr && (ioctl_index[7:6] == `CFG_IDX_SLAVE_WORM);

    // Two write cycles per host word
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            worm_hit_q <= 1'b0;
            worm_wr    <= 1'b0;
        end else begin
            worm_hit_q <= worm_hit;
            worm_wr    <= worm_hit || worm_hit_q;
        end
    end

    // Low byte first, then the high byte at the odd address
    always_ff @(posedge clk_sys) begin
        if (worm_hit) begin
            worm_adr    <= worm_adr_t'(ioctl_addr[12:0]);
            worm_data   <= ioctl_dout[7:0];
            second_byte <= ioctl_dout[15:8];
        end else begin
            worm_adr[0] <= 1'b1;
            worm_data   <= second_byte;
        end
    end

endmodule

/* hdl/nvram_sequencer.sv */
module nvram_sequencer (
    input  logic clk_sys,
    input  logic cditop_reset,
    input  logic nvram_img_mount,
    input  logic osd_opened,
    input  logic backup_pending,
    input  logic nvram_hps_ack,
    input  logic sd_buff_wr,
    input  logic buff_step,
    output logic nvram_hps_rd,
    output logic nvram_hps_wr,
    output logic backup_started,
    output logic nvram_allow_cpu_access,
    output logic adr_clear,
    output logic adr_inc,
    output logic cap_low,
    output logic cap_high,
    output logic load_restore,
    output logic nvram_restore_write
);
    import cdi_host_pkg::*;

    nvram_state_t state;

    // A mount restores first, a pending backup waits for the next menu open
    assign backup_started = (state == NVRAM_IDLE) && !nvram_img_mount &&
                            backup_pending && osd_opened;

    assign nvram_allow_cpu_access = (state == NVRAM_IDLE);
    assign adr_clear              = (state == NVRAM_IDLE);
    assign cap_low                = (state == NVRAM_BACKUP1);
    assign cap_high               = (state == NVRAM_BACKUP2);
    assign load_restore           = (state == NVRAM_RESTORE0) && sd_buff_wr;

    always_comb begin
        case (state)
            NVRAM_BACKUP0, NVRAM_BACKUP1: adr_inc = 1'b1;
            NVRAM_BACKUP3:                adr_inc = buff_step;
            NVRAM_RESTORE1, NVRAM_RESTORE2: adr_inc = 1'b1;
            default:                      adr_inc = 1'b0;
        endcase
    end

    // ==============================
    // Transfer FSM
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state               <= NVRAM_IDLE;
            nvram_hps_rd        <= 1'b0;
            nvram_hps_wr        <= 1'b0;
            nvram_restore_write <= 1'b0;
        end else begin
            nvram_restore_write <= 1'b0;

            // Requests are levels until the host acknowledges
            if (nvram_hps_ack) begin
                nvram_hps_rd <= 1'b0;
                nvram_hps_wr <= 1'b0;
            end

            case (state)
                NVRAM_IDLE: begin
                    if (nvram_img_mount) begin
                        nvram_hps_rd <= 1'b1;
                        state        <= NVRAM_WAIT_FOR_ACK;
                    end else if (backup_started) begin
                        nvram_hps_wr <= 1'b1;
                        state        <= NVRAM_WAIT_FOR_ACK;
                    end
                end
                NVRAM_WAIT_FOR_ACK: begin
                    if (nvram_hps_ack && nvram_hps_rd) begin
                        state <= NVRAM_RESTORE0;
                    end
                    if (nvram_hps_ack && nvram_hps_wr) begin
                        state <= NVRAM_BACKUP0;
                    end
                end
                // Two memory reads fill one word for the host
                NVRAM_BACKUP0: state <= NVRAM_BACKUP1;
                NVRAM_BACKUP1: state <= NVRAM_BACKUP2;
                NVRAM_BACKUP2: state <= NVRAM_BACKUP3;
                NVRAM_BACKUP3: begin
                    if (buff_step) begin
                        state <= NVRAM_BACKUP1;
                    end
                    if (!nvram_hps_ack) begin
                        state <= NVRAM_IDLE;
                    end
                end
                NVRAM_RESTORE0: begin
                    if (sd_buff_wr) begin
                        nvram_restore_write <= 1'b1;
                        state               <= NVRAM_RESTORE1;
                    end
                    if (!nvram_hps_ack) begin
                        state <= NVRAM_IDLE;
                    end
                end
                // Low byte written here, high byte in the next cycle
                NVRAM_RESTORE1: begin
                    nvram_restore_write <= 1'b1;
                    state               <= NVRAM_RESTORE2;
                end
                NVRAM_RESTORE2: state <= NVRAM_RESTORE0;
                default:        state <= NVRAM_IDLE;
            endcase
        end
    end

endmodule

/* hdl/nvram_word_packer.sv */
module nvram_word_packer (
    input  logic                      clk_sys,
    input  logic                      adr_clear,
    input  logic                      adr_inc,
    input  logic                      cap_low,
    input  logic                      cap_high,
    input  logic                      load_restore,
    input  cdi_host_pkg::host_word_t  sd_buff_dout,
    input  logic [7:0]                sd_buff_addr,
    input  cdi_host_pkg::nvram_byte_t nvram_backup_data,
    output cdi_host_pkg::nvram_adr_t  nvram_adr,
    output cdi_host_pkg::nvram_byte_t nvram_restore_data,
    output cdi_host_pkg::host_word_t  nvram_hps_din,
    output logic                      buff_step
);
    import cdi_host_pkg::*;

    host_word_t restore_word;
    logic       buff_addr0_q;

    // Even address takes the low byte of the word
    assign nvram_restore_data = nvram_adr[0] ? nvram_byte_t'(restore_word[15:8]) :
                                               nvram_byte_t'(restore_word[7:0]);

    // Host moved to the next word of the sector buffer
    assign buff_step = (sd_buff_addr[0] != buff_addr0_q);

    always_ff @(posedge clk_sys) begin
        buff_addr0_q <= sd_buff_addr[0];

        if (adr_clear) begin
            nvram_adr <= '0;
        end else if (adr_inc) begin
            nvram_adr <= nvram_adr + 1'b1;
        end

        if (load_restore) begin
            restore_word <= sd_buff_dout;
        end

        if (cap_low) begin
            nvram_hps_din[7:0] <= nvram_backup_data;
        end
        if (cap_high) begin
            nvram_hps_din[15:8] <= nvram_backup_data;
        end
    end

endmodule

/* hdl/cdi_host_bridge.sv */
`include "cdi_host_cfg.svh"

module cdi_host_bridge #(
    parameter int RAM_ZERO_WORDS = `CFG_RAM_ZERO_WORDS
) (
    input  logic                       clk_sys,
    input  logic                       cditop_reset,
    input  logic                       user_reset,
    input  logic                       reset_on_nvram_mount,
    input  logic                       osd_status,
    output logic                       core_reset,
    output logic                       backup_pending,
    // Host download
    input  logic                       ioctl_download,
    input  logic                       ioctl_wr,
    input  cdi_host_pkg::ioctl_addr_t  ioctl_addr,
    input  cdi_host_pkg::ioctl_index_t ioctl_index,
    input  cdi_host_pkg::host_word_t   ioctl_dout,
    output logic                       download_overflow,
    // SDRAM preparation
    input  logic                       sdram_busy,
    output cdi_host_pkg::sdram_addr_t  sdram_addr,
    output cdi_host_pkg::host_word_t   sdram_din,
    output logic                       sdram_wr,
    output logic                       sdram_rd,
    output logic                       sdram_refresh,
    // Slave WORM
    output cdi_host_pkg::worm_adr_t    worm_adr,
    output logic [7:0]                 worm_data,
    output logic                       worm_wr,
    // NvRAM image on the host
    input  logic                       nvram_media_change,
    input  cdi_host_pkg::img_size_t    img_size,
    input  logic                       nvram_hps_ack,
    output logic                       nvram_hps_rd,
    output logic                       nvram_hps_wr,
    output cdi_host_pkg::host_word_t   nvram_hps_din,
    input  logic                       sd_buff_wr,
    input  logic [7:0]                 sd_buff_addr,
    input  cdi_host_pkg::host_word_t   sd_buff_dout,
    // NvRAM memory
    output cdi_host_pkg::nvram_adr_t   nvram_adr,
    output cdi_host_pkg::nvram_byte_t  nvram_restore_data,
    output logic                       nvram_restore_write,
    input  cdi_host_pkg::nvram_byte_t  nvram_backup_data,
    input  logic                       nvram_cpu_changed,
    output logic                       nvram_allow_cpu_access
);

    logic ram_zero_done;
    logic nvram_img_mount;
    logic osd_opened;
    logic backup_started;
    logic adr_clear;
    logic adr_inc;
    logic cap_low;
    logic cap_high;
    logic load_restore;
    logic buff_step;

    media_status i_media_status (
        .clk_sys              (clk_sys),
        .cditop_reset         (cditop_reset),
        .user_reset           (user_reset),
        .ioctl_download       (ioctl_download),
        .ram_zero_done        (ram_zero_done),
        .reset_on_nvram_mount (reset_on_nvram_mount),
        .nvram_media_change   (nvram_media_change),
        .img_size             (img_size),
        .nvram_cpu_changed    (nvram_cpu_changed),
        .osd_status           (osd_status),
        .backup_started       (backup_started),
        .core_reset           (core_reset),
        .nvram_img_mount      (nvram_img_mount),
        .osd_opened           (osd_opened),
        .backup_pending       (backup_pending)
    );

    sdram_prep_arbiter #(
        .RAM_ZERO_WORDS (RAM_ZERO_WORDS)
    ) i_sdram_prep_arbiter (
        .clk_sys           (clk_sys),
        .cditop_reset      (cditop_reset),
        .core_reset        (core_reset),
        .sdram_busy        (sdram_busy),
        .ioctl_download    (ioctl_download),
        .ioctl_wr          (ioctl_wr),
        .ioctl_addr        (ioctl_addr),
        .ioctl_index       (ioctl_index),
        .ioctl_dout        (ioctl_dout),
        .sdram_addr        (sdram_addr),
        .sdram_din         (sdram_din),
        .sdram_wr          (sdram_wr),
        .sdram_rd          (sdram_rd),
        .sdram_refresh     (sdram_refresh),
        .ram_zero_done     (ram_zero_done),
        .download_overflow (download_overflow)
    );

    worm_byte_splitter i_worm_byte_splitter (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .ioctl_wr     (ioctl_wr),
        .ioctl_index  (ioctl_index),
        .ioctl_addr   (ioctl_addr),
        .ioctl_dout   (ioctl_dout),
        .worm_adr     (worm_adr),
        .worm_data    (worm_data),
        .worm_wr      (worm_wr)
    );

    nvram_sequencer i_nvram_sequencer (
        .clk_sys                (clk_sys),
        .cditop_reset           (cditop_reset),
        .nvram_img_mount        (nvram_img_mount),
        .osd_opened             (osd_opened),
        .backup_pending         (backup_pending),
        .nvram_hps_ack          (nvram_hps_ack),
        .sd_buff_wr             (sd_buff_wr),
        .buff_step              (buff_step),
        .nvram_hps_rd           (nvram_hps_rd),
        .nvram_hps_wr           (nvram_hps_wr),
        .backup_started         (backup_started),
        .nvram_allow_cpu_access (nvram_allow_cpu_access),
        .adr_clear              (adr_clear),
        .adr_inc                (adr_inc),
        .cap_low                (cap_low),
        .cap_high               (cap_high),
        .load_restore           (load_restore),
        .nvram_restore_write    (nvram_restore_write)
    );

    nvram_word_packer i_nvram_word_packer (
        .clk_sys            (clk_sys),
        .adr_clear          (adr_clear),
        .adr_inc            (adr_inc),
        .cap_low            (cap_low),
        .cap_high           (cap_high),
        .load_restore       (load_restore),
        .sd_buff_dout       (sd_buff_dout),
        .sd_buff_addr       (sd_buff_addr),
        .nvram_backup_data  (nvram_backup_data),
        .nvram_adr          (nvram_adr),
        .nvram_restore_data (nvram_restore_data),
        .nvram_hps_din      (nvram_hps_din),
        .buff_step          (buff_step)
    );

endmodule

/* tb/cdi_host_bridge_tb.sv */
module cdi_host_bridge_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import cdi_host_pkg::*;

    localparam int ZERO_WORDS = 16;
    localparam int RESTORE_WORDS = 4;
    // Worst-case cycles of tests 1 to 6 plus reset
    localparam int WATCHDOG_NS = (20 + 250 + 400 + 350 + 20 + 120 + 120) * 10;

    logic        clk_sys;
    logic        cditop_reset;
    logic        user_reset;
    logic        reset_on_nvram_mount;
    logic        osd_status;
    logic        core_reset;
    logic        backup_pending;
    logic        ioctl_download;
    logic        ioctl_wr;
    ioctl_addr_t ioctl_addr;
    ioctl_index_t ioctl_index;
    host_word_t  ioctl_dout;
    logic        download_overflow;
    logic        sdram_busy;
    sdram_addr_t sdram_addr;
    host_word_t  sdram_din;
    logic        sdram_wr;
    logic        sdram_rd;
    logic        sdram_refresh;
    worm_adr_t   worm_adr;
    logic [7:0]  worm_data;
    logic        worm_wr;
    logic        nvram_media_change;
    img_size_t   img_size;
    logic        nvram_hps_ack;
    logic        nvram_hps_rd;
    logic        nvram_hps_wr;
    host_word_t  nvram_hps_din;
    logic        sd_buff_wr;
    logic [7:0]  sd_buff_addr;
    host_word_t  sd_buff_dout;
    nvram_adr_t  nvram_adr;
    nvram_byte_t nvram_restore_data;
    logic        nvram_restore_write;
    nvram_byte_t nvram_backup_data;
    logic        nvram_cpu_changed;
    logic        nvram_allow_cpu_access;

    // Commands seen by the SDRAM model
    sdram_addr_t zero_addr_q[$];
    host_word_t  zero_data_q[$];
    sdram_addr_t rom_addr_q[$];
    host_word_t  rom_data_q[$];
    int          refresh_cnt;
    int          busy_left;
    nvram_byte_t nvram_mem [0:8191];

    cdi_host_bridge #(
        .RAM_ZERO_WORDS (ZERO_WORDS)
    ) i_cdi_host_bridge (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    // ==============================
    // SDRAM busy model
    // ==============================
    initial begin
        void'($urandom(32'he3ec));
        sdram_busy = 1'b0;
        busy_left  = 0;
        forever begin
            @(posedge clk_sys);
            if (cditop_reset) begin
                sdram_busy <= 1'b0;
                busy_left = 0;
            end else if (busy_left > 0) begin
                busy_left = busy_left - 1;
                if (busy_left == 0) begin
                    sdram_busy <= 1'b0;
                end
            end else if (sdram_wr || sdram_rd) begin
                if (sdram_wr && sdram_addr[24:20] == 5'b00100) begin
                    rom_addr_q.push_back(sdram_addr);
                    rom_data_q.push_back(sdram_din);
                end else if (sdram_wr) begin
                    zero_addr_q.push_back(sdram_addr);
                    zero_data_q.push_back(sdram_din);
                end else if (sdram_refresh) begin
                    refresh_cnt = refresh_cnt + 1;
                end else begin
                    fail_now("SDRAM read issued without the refresh flag");
                end
                sdram_busy <= 1'b1;
                busy_left = $urandom_range(4, 1);
            end
        end
    end

    // NvRAM model, read data one cycle after the address
    always @(posedge clk_sys) begin
        nvram_backup_data <= nvram_mem[nvram_adr];
        if (nvram_restore_write) begin
            nvram_mem[nvram_adr] <= nvram_restore_data;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now("Timeout, the watchdog limit was reached");
    end

    task automatic fail_now(input string what);
        $display("%s at %0t ns", what, $time);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // One falling edge of waiting, bounded
    task automatic step_bounded(inout int cnt, input int limit, input string what);
        @(negedge clk_sys);
        cnt++;
        if (cnt > limit) begin
            fail_now(what);
        end
    endtask

    task automatic host_ioctl_write(input ioctl_index_t idx, input ioctl_addr_t adr,
                                    input host_word_t dout);
        ioctl_wr    = 1'b1;
        ioctl_index = idx;
        ioctl_addr  = adr;
        ioctl_dout  = dout;
        @(negedge clk_sys);
        ioctl_wr = 1'b0;
    endtask

    task automatic wait_core_reset_low(input int limit);
        int cnt;
        cnt = 0;
        while (core_reset) step_bounded(cnt, limit, "core_reset never fell");
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic zeroing_after_reset();
        int cnt;
        int n;
        cnt = 0;
        while (zero_addr_q.size() < ZERO_WORDS) step_bounded(cnt, 150, "RAM zeroing stalled");
        check_value("refresh count during zeroing", refresh_cnt, 0);
        for (int i = 0; i < ZERO_WORDS; i++) begin
            check_value("sdram_addr (zero)", zero_addr_q[i], 2 * i);
            check_value("sdram_din (zero)", zero_data_q[i], 0);
        end
        cnt = 0;
        while (sdram_busy) step_bounded(cnt, 10, "last zero write never completed");
        n = 0;
        while (core_reset) step_bounded(n, 10, "core_reset stayed high after zeroing");
        check_value("cycles from busy fall to core_reset fall", n, 2);
        repeat (8) @(negedge clk_sys);
        check_value("refresh seen after zeroing", refresh_cnt > 0, 1);
    endtask

    task automatic rom_download_writes();
        int cnt;
        int zeros_before;
        zero_addr_q.delete();
        ioctl_download = 1'b1;
        repeat (3) @(negedge clk_sys);
        zeros_before = zero_addr_q.size();
        host_ioctl_write(16'h0000, 25'h0012346, 16'hbeef);
        cnt = 0;
        while (rom_addr_q.size() < 1) step_bounded(cnt, 20, "main ROM write missing");
        // Only the zero write already under way may come before the ROM word
        check_value("zero writes ahead of ROM write",
                    zero_addr_q.size() - zeros_before <= 1, 1);
        check_value("sdram_addr (main ROM)", rom_addr_q[0], {5'b00100, 1'b0, 18'h091a3, 1'b0});
        check_value("sdram_din (main ROM)", rom_data_q[0], 16'hefbe);
        repeat (8) @(negedge clk_sys);
        host_ioctl_write(16'h0080, 25'h007fffe, 16'h1234);
        cnt = 0;
        while (rom_addr_q.size() < 2) step_bounded(cnt, 20, "VMPEG ROM write missing");
        check_value("sdram_addr (VMPEG ROM)", rom_addr_q[1], {5'b00100, 1'b1, 18'h3ffff, 1'b0});
        check_value("sdram_din (VMPEG ROM)", rom_data_q[1], 16'h3412);
        check_value("download_overflow", download_overflow, 0);
        repeat (4) @(negedge clk_sys);
        ioctl_download = 1'b0;
        wait_core_reset_low(200);
        check_value("ROM write count", rom_addr_q.size(), 2);
    endtask

    task automatic download_overflow_sticky();
        ioctl_download = 1'b1;
        repeat (3) @(negedge clk_sys);
        host_ioctl_write(16'h0000, 25'h0000010, 16'h0102);
        repeat (2) @(negedge clk_sys);
        host_ioctl_write(16'h0000, 25'h0000012, 16'h0304);
        check_value("download_overflow", download_overflow, 1);
        repeat (20) @(negedge clk_sys);
        check_value("download_overflow (sticky)", download_overflow, 1);
        ioctl_download = 1'b0;
        wait_core_reset_low(300);
    endtask

    task automatic worm_byte_writes();
        host_ioctl_write(16'h0040, 25'h1ff5a4, 16'hc3a5);
        check_value("worm_wr (low byte)", worm_wr, 1);
        check_value("worm_adr (low byte)", worm_adr, 13'h15a4);
        check_value("worm_data (low byte)", worm_data, 8'ha5);
        @(negedge clk_sys);
        check_value("worm_wr (high byte)", worm_wr, 1);
        check_value("worm_adr (high byte)", worm_adr, 13'h15a5);
        check_value("worm_data (high byte)", worm_data, 8'hc3);
        @(negedge clk_sys);
        check_value("worm_wr (after burst)", worm_wr, 0);
    endtask

    task automatic nvram_restore();
        int cnt;
        host_word_t word;
        img_size           = 64'h2000;
        nvram_media_change = 1'b1;
        @(negedge clk_sys);
        nvram_media_change = 1'b0;
        cnt = 0;
        while (!nvram_hps_rd) step_bounded(cnt, 5, "restore request never rose");
        nvram_hps_ack = 1'b1;
        repeat (2) @(negedge clk_sys);
        check_value("nvram_hps_rd after ack", nvram_hps_rd, 0);
        for (int k = 0; k < RESTORE_WORDS; k++) begin
            word         = 16'h9100 + 16'h0111 * k;
            sd_buff_wr   = 1'b1;
            sd_buff_dout = word;
            @(negedge clk_sys);
            sd_buff_wr = 1'b0;
            check_value("nvram_allow_cpu_access (restore)", nvram_allow_cpu_access, 0);
            repeat (4) @(negedge clk_sys);
        end
        nvram_hps_ack = 1'b0;
        repeat (2) @(negedge clk_sys);
        check_value("nvram_allow_cpu_access (idle)", nvram_allow_cpu_access, 1);
        for (int k = 0; k < RESTORE_WORDS; k++) begin
            word = 16'h9100 + 16'h0111 * k;
            check_value("NvRAM even byte", nvram_mem[2 * k], word[7:0]);
            check_value("NvRAM odd byte", nvram_mem[2 * k + 1], word[15:8]);
        end
    endtask

    task automatic nvram_backup();
        int cnt;
        nvram_cpu_changed = 1'b1;
        @(negedge clk_sys);
        nvram_cpu_changed = 1'b0;
        check_value("backup_pending after core change", backup_pending, 1);
        osd_status = 1'b1;
        @(negedge clk_sys);
        check_value("backup_pending at backup start", backup_pending, 0);
        cnt = 0;
        while (!nvram_hps_wr) step_bounded(cnt, 5, "backup request never rose");
        nvram_hps_ack = 1'b1;
        for (int k = 0; k < RESTORE_WORDS + 2; k++) begin
            repeat (6) @(negedge clk_sys);
            check_value("nvram_hps_din", nvram_hps_din,
                        {nvram_mem[2 * k + 1], nvram_mem[2 * k]});
            sd_buff_addr = sd_buff_addr + 1'b1;
        end
        repeat (4) @(negedge clk_sys);
        nvram_hps_ack = 1'b0;
        osd_status    = 1'b0;
        repeat (2) @(negedge clk_sys);
        check_value("nvram_allow_cpu_access after backup", nvram_allow_cpu_access, 1);
    endtask

    initial begin
        refresh_cnt          = 0;
        cditop_reset         = 1'b1;
        user_reset           = 1'b0;
        reset_on_nvram_mount = 1'b0;
        osd_status           = 1'b0;
        ioctl_download       = 1'b0;
        ioctl_wr             = 1'b0;
        ioctl_addr           = '0;
        ioctl_index          = '0;
        ioctl_dout           = '0;
        nvram_media_change   = 1'b0;
        img_size             = '0;
        nvram_hps_ack        = 1'b0;
        sd_buff_wr           = 1'b0;
        sd_buff_addr         = '0;
        sd_buff_dout         = '0;
        nvram_backup_data    = '0;
        nvram_cpu_changed    = 1'b0;
        for (int a = 0; a < 8192; a++) begin
            nvram_mem[a] = nvram_byte_t'(a[7:0] ^ {3'b000, a[12:8]} ^ 8'h5a);
        end

        repeat (4) @(negedge clk_sys);
        cditop_reset = 1'b0;

        zeroing_after_reset();
        rom_download_writes();
        download_overflow_sticky();
        worm_byte_writes();
        nvram_restore();
        nvram_backup();

        $display("All tests passed!");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
hdl/cdi_host_pkg.sv
hdl/media_status.sv
hdl/sdram_prep_arbiter.sv
hdl/worm_byte_splitter.sv
hdl/nvram_sequencer.sv
hdl/nvram_word_packer.sv
hdl/cdi_host_bridge.sv
tb/cdi_host_bridge_tb.sv

/* Bender.yml */
package:
  name: cdi_host_bridge

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cdi_host_pkg.sv
      - hdl/media_status.sv
      - hdl/sdram_prep_arbiter.sv
      - hdl/worm_byte_splitter.sv
      - hdl/nvram_sequencer.sv
      - hdl/nvram_word_packer.sv
      - hdl/cdi_host_bridge.sv
  - target: test
    files:
      - tb/cdi_host_bridge_tb.sv
